/* sd_cmd_pkg.sv */
// SD command path shared definitions
// Transceiver states, error codes, response kinds, handshake payloads,
// Wishbone request/response bundles and the register word map
`default_nettype none

package sd_cmd_pkg;

    // States before CMDSTATE_RESP_WAIT own the CMD line
    typedef enum logic [3:0] {
        CMDSTATE_IDLE,
        CMDSTATE_REQ_CONTENT,
        CMDSTATE_REQ_CRC7,
        CMDSTATE_REQ_STOPBIT,
        CMDSTATE_RESP_WAIT,
        CMDSTATE_RESP_TRANSBIT,
        CMDSTATE_RESP_CMD_MIRROR,
        CMDSTATE_RESP_REG,
        CMDSTATE_RESP_CRC7,
        CMDSTATE_RESP_STOPBIT
    } cmd_state_e;

    typedef enum logic [2:0] {
        CMDERR_NONE,
        CMDERR_NO_RESPONSE,
        CMDERR_WRONG_RESP_STARTBIT,
        CMDERR_WRONG_RESP_STOPBIT,
        CMDERR_BAD_CRC
    } cmd_err_e;

    // R3 (OCR) has no CRC protection
    typedef enum logic [1:0] {
        RESP_R1,
        RESP_R3,
        RESP_R6
    } resp_kind_e;

    typedef struct packed {
        logic [5:0]  cmd;
        logic [31:0] arg;
        resp_kind_e  kind;
    } cmd_req_t;

    typedef struct packed {
        logic [5:0]  cmd;
        logic [31:0] reg_val;
        logic [6:0]  crc_rx;
        logic [6:0]  crc_calc;
    } cmd_resp_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        REG_CTRL,
        REG_WATCHDOG,
        REG_ARG,
        REG_CMD,
        REG_STATUS,
        REG_RESP_CMD,
        REG_RESP_REG,
        REG_RESP_CRC
    } reg_addr_e;

endpackage

`default_nettype wire

/* sd_clk_gen.sv */
// SD card clock generator
// Divides i_clk by 2*(div+1) and flags each card clock edge one cycle early
`timescale 1ns/10ps
`default_nettype none

module sd_clk_gen #(
    parameter int DIV_WIDTH = 8
) (
    input  wire logic                 i_clk,
    input  wire logic                 i_nrst,
    input  wire logic [DIV_WIDTH-1:0] i_div,
    output logic                      o_sclk,
    output logic                      o_sclk_posedge,
    output logic                      o_sclk_negedge
);

    logic [DIV_WIDTH-1:0] r_cnt;
    logic                 r_sclk;
    logic                 tick;

    // Counter expiry means the card clock toggles on the next i_clk edge
    assign tick = (r_cnt == '0);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_cnt  <= '0;
            r_sclk <= 1'b0;
        end else if (tick) begin
            r_cnt  <= i_div;
            r_sclk <= !r_sclk;
        end else begin
            r_cnt <= r_cnt - 1'b1;
        end
    end

    assign o_sclk         = r_sclk;
    assign o_sclk_posedge = tick && !r_sclk;
    assign o_sclk_negedge = tick && r_sclk;

endmodule

`default_nettype wire

/* sd_crc7.sv */
// Bit-serial CRC7 for SD command frames
// Polynomial x^7 + x^3 + 1, one bit per step, clear wins over step
`timescale 1ns/10ps
`default_nettype none

module sd_crc7 (
    input  wire logic i_clk,
    input  wire logic i_nrst,
    input  wire logic i_clear,
    input  wire logic i_next,
    input  wire logic i_dat,
    output logic [6:0] o_crc7
);

    logic [6:0] r_crc;
    logic       fb;

    assign fb = i_dat ^ r_crc[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_crc <= '0;
        end else if (i_clear) begin
            r_crc <= '0;
        end else if (i_next) begin
            // Feedback lands on bits 3 and 0
            r_crc <= {r_crc[5:3], r_crc[2] ^ fb, r_crc[1:0], fb};
        end
    end

    assign o_crc7 = r_crc;

endmodule

`default_nettype wire

/* sd_cmd_transceiver.sv */
// SD command line transceiver
// Sends the 48-bit command frame with CRC7 on falling card clock edges,
// then turns the line around and receives a 48-bit response on rising edges
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_transceiver (
    input  wire logic                  i_clk,
    input  wire logic                  i_nrst,
    input  wire logic                  i_sclk_posedge,
    input  wire logic                  i_sclk_negedge,
    input  wire logic                  i_cmd,
    output logic                       o_cmd,
    output logic                       o_cmd_dir,
    input  wire logic [15:0]           i_watchdog,
    input  wire logic                  i_req_valid,
    input  wire sd_cmd_pkg::cmd_req_t  i_req,
    output logic                       o_req_ready,
    input  wire logic [6:0]            i_crc7,
    output logic                       o_crc7_clear,
    output logic                       o_crc7_next,
    output logic                       o_crc7_dat,
    output logic                       o_resp_valid,
    output sd_cmd_pkg::cmd_resp_t      o_resp,
    input  wire logic                  i_resp_ready,
    input  wire logic                  i_clear_err,
    output sd_cmd_pkg::cmd_err_e       o_err
);

    import sd_cmd_pkg::*;

    cmd_state_e  r_state;
    cmd_err_e    r_err;
    logic [39:0] r_shift;
    logic [5:0]  r_bitcnt;
    logic [15:0] r_wdog;
    logic        r_resp_valid;
    resp_kind_e  r_kind;
    logic [5:0]  r_mirror;
    logic [31:0] r_reg_val;
    logic [6:0]  r_crc_rx;
    logic [6:0]  r_crc_calc;
    logic        accept;

    assign o_req_ready = i_sclk_negedge && (r_state == CMDSTATE_IDLE)
                         && (r_err == CMDERR_NONE);
    assign accept      = o_req_ready && i_req_valid;

    // CRC steps with each bit as it is put on the line, so the sum is
    // settled one half-period before the CRC field must be driven
    always_comb begin
        o_crc7_clear = 1'b0;
        o_crc7_next  = 1'b0;
        o_crc7_dat   = 1'b0;
        case (r_state)
            CMDSTATE_IDLE: begin
                // Start bit is 0
                o_crc7_clear = !accept;
                o_crc7_next  = accept;
            end
            CMDSTATE_REQ_CONTENT: begin
                o_crc7_next = i_sclk_negedge && (r_bitcnt != '0);
                o_crc7_dat  = r_shift[38];
            end
            CMDSTATE_REQ_STOPBIT: begin
                o_crc7_clear = 1'b1;
            end
            CMDSTATE_RESP_WAIT: begin
                o_crc7_next = i_sclk_posedge && !i_cmd;
                o_crc7_dat  = i_cmd;
            end
            CMDSTATE_RESP_TRANSBIT, CMDSTATE_RESP_CMD_MIRROR, CMDSTATE_RESP_REG: begin
                o_crc7_next = i_sclk_posedge;
                o_crc7_dat  = i_cmd;
            end
            default: begin
                o_crc7_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_state      <= CMDSTATE_IDLE;
            r_err        <= CMDERR_NONE;
            r_shift      <= '1;
            r_bitcnt     <= '0;
            r_wdog       <= '0;
            r_resp_valid <= 1'b0;
        end else begin
            if (i_clear_err) begin
                r_err <= CMDERR_NONE;
            end
            if (i_resp_ready) begin
                r_resp_valid <= 1'b0;
            end

            if (i_sclk_negedge) begin
                case (r_state)
                    CMDSTATE_IDLE: begin
                        if (accept) begin
                            r_shift  <= {2'b01, i_req.cmd, i_req.arg};
                            r_bitcnt <= 6'd39;
                            r_state  <= CMDSTATE_REQ_CONTENT;
                        end
                    end
                    CMDSTATE_REQ_CONTENT: begin
                        if (r_bitcnt != '0) begin
                            r_shift  <= {r_shift[38:0], 1'b1};
                            r_bitcnt <= r_bitcnt - 6'd1;
                        end else begin
                            // CRC field followed by ones for the end bit
                            r_shift  <= {i_crc7, 33'h1_ffff_ffff};
                            r_bitcnt <= 6'd6;
                            r_state  <= CMDSTATE_REQ_CRC7;
                        end
                    end
                    CMDSTATE_REQ_CRC7: begin
                        r_shift <= {r_shift[38:0], 1'b1};
                        if (r_bitcnt != '0) begin
                            r_bitcnt <= r_bitcnt - 6'd1;
                        end else begin
                            r_state <= CMDSTATE_REQ_STOPBIT;
                        end
                    end
                    CMDSTATE_REQ_STOPBIT: begin
                        r_wdog  <= i_watchdog;
                        r_state <= CMDSTATE_RESP_WAIT;
                    end
                    default: begin
                        r_state <= r_state;
                    end
                endcase
            end

            if (i_sclk_posedge) begin
                case (r_state)
                    CMDSTATE_RESP_WAIT: begin
                        if (!i_cmd) begin
                            r_state <= CMDSTATE_RESP_TRANSBIT;
                        end else if (r_wdog == '0) begin
                            r_err   <= CMDERR_NO_RESPONSE;
                            r_state <= CMDSTATE_IDLE;
                        end else begin
                            r_wdog <= r_wdog - 16'd1;
                        end
                    end
                    CMDSTATE_RESP_TRANSBIT: begin
                        // Card to host transmission bit is 0
                        if (!i_cmd) begin
                            r_bitcnt <= 6'd5;
                            r_state  <= CMDSTATE_RESP_CMD_MIRROR;
                        end else begin
                            r_err   <= CMDERR_WRONG_RESP_STARTBIT;
                            r_state <= CMDSTATE_IDLE;
                        end
                    end
                    CMDSTATE_RESP_CMD_MIRROR: begin
                        if (r_bitcnt != '0) begin
                            r_bitcnt <= r_bitcnt - 6'd1;
                        end else begin
                            r_bitcnt <= 6'd31;
                            r_state  <= CMDSTATE_RESP_REG;
                        end
                    end
                    CMDSTATE_RESP_REG: begin
                        if (r_bitcnt != '0) begin
                            r_bitcnt <= r_bitcnt - 6'd1;
                        end else begin
                            r_bitcnt <= 6'd6;
                            r_state  <= CMDSTATE_RESP_CRC7;
                        end
                    end
                    CMDSTATE_RESP_CRC7: begin
                        if (r_bitcnt != '0) begin
                            r_bitcnt <= r_bitcnt - 6'd1;
                        end else begin
                            r_state <= CMDSTATE_RESP_STOPBIT;
                        end
                    end
                    CMDSTATE_RESP_STOPBIT: begin
                        // Stop bit error outranks a CRC mismatch
                        if (!i_cmd) begin
                            r_err <= CMDERR_WRONG_RESP_STOPBIT;
                        end else if (r_kind != RESP_R3 && r_crc_rx != i_crc7) begin
                            r_err <= CMDERR_BAD_CRC;
                        end
                        r_resp_valid <= 1'b1;
                        r_state      <= CMDSTATE_IDLE;
                    end
                    default: begin
                        r_state <= r_state;
                    end
                endcase
            end
        end
    end

    // Response fields
    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_kind <= i_req.kind;
        end
        if (i_sclk_posedge) begin
            case (r_state)
                CMDSTATE_RESP_CMD_MIRROR: r_mirror  <= {r_mirror[4:0], i_cmd};
                CMDSTATE_RESP_REG:        r_reg_val <= {r_reg_val[30:0], i_cmd};
                CMDSTATE_RESP_CRC7:       r_crc_rx  <= {r_crc_rx[5:0], i_cmd};
                CMDSTATE_RESP_STOPBIT:    r_crc_calc <= i_crc7;
                default: begin
                    r_crc_calc <= r_crc_calc;
                end
            endcase
        end
    end

    assign o_cmd        = r_shift[39];
    assign o_cmd_dir    = (r_state < CMDSTATE_RESP_WAIT);
    assign o_resp_valid = r_resp_valid;
    assign o_err        = r_err;
    assign o_resp       = '{cmd: r_mirror, reg_val: r_reg_val,
                            crc_rx: r_crc_rx, crc_calc: r_crc_calc};

endmodule

`default_nettype wire

/* sd_wb_regs.sv */
// Wishbone classic register bank for the SD command controller
// Holds clock and watchdog setup, issues commands to the transceiver
// and keeps the last response and status
`timescale 1ns/10ps
`default_nettype none

module sd_wb_regs #(
    parameter int DIV_WIDTH = 8
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_nrst,
    input  wire sd_cmd_pkg::wb_req_t   i_wb,
    output sd_cmd_pkg::wb_rsp_t        o_wb,
    output logic [DIV_WIDTH-1:0]       o_div,
    output logic [15:0]                o_watchdog,
    output logic                       o_req_valid,
    output sd_cmd_pkg::cmd_req_t       o_req,
    input  wire logic                  i_req_ready,
    input  wire logic                  i_resp_valid,
    input  wire sd_cmd_pkg::cmd_resp_t i_resp,
    output logic                       o_resp_ready,
    input  wire sd_cmd_pkg::cmd_err_e  i_err,
    output logic                       o_clear_err
);

    import sd_cmd_pkg::*;

    reg_addr_e            adr;
    logic                 access;
    logic                 cmd_wr;
    logic                 status_wr;
    logic                 finish;
    logic [31:0]          rd_mux;
    logic                 r_ack;
    logic [31:0]          r_rdata;
    logic [DIV_WIDTH-1:0] r_div;
    logic [15:0]          r_wdog;
    logic [31:0]          r_arg;
    logic                 r_busy;
    logic                 r_done;
    logic                 r_req_valid;
    cmd_req_t             r_req;
    cmd_resp_t            r_resp;

    assign adr    = reg_addr_e'(i_wb.adr);
    // New cycle seen, the ack cycle itself is not a new access
    assign access    = i_wb.cyc && i_wb.stb && !r_ack;
    assign cmd_wr    = access && i_wb.we && (adr == REG_CMD);
    assign status_wr = access && i_wb.we && (adr == REG_STATUS);

    // Error completion only counts once the request has been taken
    assign finish = r_busy && !r_req_valid && (i_resp_valid || i_err != CMDERR_NONE);

    always_comb begin
        case (adr)
            REG_CTRL:     rd_mux = 32'(r_div);
            REG_WATCHDOG: rd_mux = {16'h0, r_wdog};
            REG_ARG:      rd_mux = r_arg;
            REG_CMD:      rd_mux = {22'h0, r_req.kind, 2'b00, r_req.cmd};
            REG_STATUS:   rd_mux = {25'h0, i_err, 2'b00, r_done, r_busy};
            REG_RESP_CMD: rd_mux = {26'h0, r_resp.cmd};
            REG_RESP_REG: rd_mux = r_resp.reg_val;
            REG_RESP_CRC: rd_mux = {17'h0, r_resp.crc_calc, 1'b0, r_resp.crc_rx};
            default:      rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_ack       <= 1'b0;
            r_div       <= '0;
            r_wdog      <= '0;
            r_busy      <= 1'b0;
            r_done      <= 1'b0;
            r_req_valid <= 1'b0;
        end else begin
            r_ack <= access;
            if (access && i_wb.we && adr == REG_CTRL) begin
                r_div <= i_wb.dat[DIV_WIDTH-1:0];
            end
            if (access && i_wb.we && adr == REG_WATCHDOG) begin
                r_wdog <= i_wb.dat[15:0];
            end
            if (r_req_valid && i_req_ready) begin
                r_req_valid <= 1'b0;
            end
            if (status_wr) begin
                r_done <= 1'b0;
            end
            if (finish) begin
                r_busy <= 1'b0;
                r_done <= 1'b1;
            end
            // CMD writes while busy are dropped
            if (cmd_wr && !r_busy) begin
                r_busy      <= 1'b1;
                r_req_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (access) begin
            r_rdata <= rd_mux;
        end
        if (access && i_wb.we && adr == REG_ARG) begin
            r_arg <= i_wb.dat;
        end
        if (cmd_wr && !r_busy) begin
            r_req <= '{cmd: i_wb.dat[5:0], arg: r_arg, kind: resp_kind_e'(i_wb.dat[9:8])};
        end
        if (i_resp_valid) begin
            r_resp <= i_resp;
        end
    end

    assign o_wb         = '{ack: r_ack, dat: r_rdata};
    assign o_div        = r_div;
    assign o_watchdog   = r_wdog;
    assign o_req_valid  = r_req_valid;
    assign o_req        = r_req;
    assign o_resp_ready = 1'b1;
    assign o_clear_err  = status_wr;

endmodule

`default_nettype wire

/* sd_cmd_top.sv */
// SD command-line controller top level
// Wishbone register bank, card clock divider, CRC7 unit and CMD transceiver
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_top #(
    parameter int DIV_WIDTH = 8
) (
    input  wire logic                i_clk,
    input  wire logic                i_nrst,
    input  wire sd_cmd_pkg::wb_req_t i_wb,
    output sd_cmd_pkg::wb_rsp_t      o_wb,
    output logic                     o_sd_clk,
    output logic                     o_sd_cmd,
    output logic                     o_sd_cmd_oe,
    input  wire logic                i_sd_cmd
);

    import sd_cmd_pkg::*;

    logic [DIV_WIDTH-1:0] div;
    logic [15:0]          watchdog;
    logic                 req_valid;
    logic                 req_ready;
    cmd_req_t             req;
    logic                 resp_valid;
    logic                 resp_ready;
    cmd_resp_t            resp;
    cmd_err_e             err;
    logic                 clear_err;
    logic                 sclk_posedge;
    logic                 sclk_negedge;
    logic [6:0]           crc7;
    logic                 crc7_clear;
    logic                 crc7_next;
    logic                 crc7_dat;

    sd_wb_regs #(
        .DIV_WIDTH(DIV_WIDTH)
    ) i_regs (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_wb         (i_wb),
        .o_wb         (o_wb),
        .o_div        (div),
        .o_watchdog   (watchdog),
        .o_req_valid  (req_valid),
        .o_req        (req),
        .i_req_ready  (req_ready),
        .i_resp_valid (resp_valid),
        .i_resp       (resp),
        .o_resp_ready (resp_ready),
        .i_err        (err),
        .o_clear_err  (clear_err)
    );

    sd_clk_gen #(
        .DIV_WIDTH(DIV_WIDTH)
    ) i_clk_gen (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_div          (div),
        .o_sclk         (o_sd_clk),
        .o_sclk_posedge (sclk_posedge),
        .o_sclk_negedge (sclk_negedge)
    );

    sd_crc7 i_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc7_clear),
        .i_next  (crc7_next),
        .i_dat   (crc7_dat),
        .o_crc7  (crc7)
    );

    sd_cmd_transceiver i_xcvr (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_sclk_posedge (sclk_posedge),
        .i_sclk_negedge (sclk_negedge),
        .i_cmd          (i_sd_cmd),
        .o_cmd          (o_sd_cmd),
        .o_cmd_dir      (o_sd_cmd_oe),
        .i_watchdog     (watchdog),
        .i_req_valid    (req_valid),
        .i_req          (req),
        .o_req_ready    (req_ready),
        .i_crc7         (crc7),
        .o_crc7_clear   (crc7_clear),
        .o_crc7_next    (crc7_next),
        .o_crc7_dat     (crc7_dat),
        .o_resp_valid   (resp_valid),
        .o_resp         (resp),
        .i_resp_ready   (resp_ready),
        .i_clear_err    (clear_err),
        .o_err          (err)
    );

endmodule

`default_nettype wire

/* tb_sd_cmd_top.sv */
// Testbench for the SD command-line controller
// Drives the Wishbone bank with LFSR stimulus, models an SD card on the CMD line
// and checks frames, responses and error codes against a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_sd_cmd_top;

    import sd_cmd_pkg::*;

    localparam int     DIV_WIDTH     = 8;
    localparam int     CLK_PERIOD    = 40;
    localparam int     N_ROUNDS      = 3;
    localparam int     MAX_DIV       = 3;
    localparam int     CMD_PERIODS   = 48 + 2 + 16 + 48 + 8;
    localparam int     HOLD_PERIODS  = 64;
    localparam int     MAX_POLLS     = 2000;
    localparam longint TIMEOUT_NS    = longint'(N_ROUNDS * 7) * (CMD_PERIODS + HOLD_PERIODS)
                                       * 2 * (MAX_DIV + 1) * CLK_PERIOD + 200000;
    localparam int     CARD_GOOD     = 0;
    localparam int     CARD_SILENT   = 1;
    localparam int     CARD_BAD_CRC  = 2;
    localparam int     CARD_BAD_STOP = 3;

    logic        clk;
    logic        nrst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        sd_clk;
    logic        sd_cmd_out;
    logic        sd_cmd_oe;
    logic        sd_cmd_in;
    logic [31:0] lfsr_state = 32'hc0f9;

    // Card behaviour for the next command
    int          card_mode;
    logic [5:0]  card_cmd;
    logic [31:0] card_val;
    int          card_delay;
    int          frame_count;
    logic [47:0] last_frame;

    // Reference values for the command in flight
    resp_kind_e  cur_kind;
    logic [5:0]  cur_cmd;
    logic [31:0] cur_arg;
    int          frames_sent;
    logic [47:0] exp_frame;
    cmd_resp_t   exp_resp;
    cmd_err_e    exp_err;
    logic [31:0] sd_div;

    sd_cmd_top #(
        .DIV_WIDTH(DIV_WIDTH)
    ) i_dut (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_wb        (wb_req),
        .o_wb        (wb_rsp),
        .o_sd_clk    (sd_clk),
        .o_sd_cmd    (sd_cmd_out),
        .o_sd_cmd_oe (sd_cmd_oe),
        .i_sd_cmd    (sd_cmd_in)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // CRC7 over 40 bits MSB first with generator x^7 + x^3 + 1
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_frame(input logic [47:0] got, input logic [47:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: command frame got %h expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_resp(input cmd_resp_t got, input cmd_resp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: response got %h/%h/%h/%h expected %h/%h/%h/%h",
                                $time, got.cmd, got.reg_val, got.crc_rx, got.crc_calc,
                                exp.cmd, exp.reg_val, exp.crc_rx, exp.crc_calc));
        end
    endtask

    task automatic check_err(input cmd_err_e got, input cmd_err_e exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0t: error code got %s expected %s",
                                $time, got.name(), exp.name()));
        end
    endtask

    task automatic wb_cycle(input logic we, input reg_addr_e adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        int n;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < 8);
        if (!wb_rsp.ack) begin
            abort_run($sformatf("No Wishbone ack for register %s", adr.name()));
        end
        rdat   = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic wb_write(input reg_addr_e adr, input logic [31:0] wdat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input reg_addr_e adr, output logic [31:0] rdat);
        wb_cycle(1'b0, adr, 32'h0, rdat);
    endtask

    task automatic wait_done(output logic [31:0] st);
        int polls;
        polls = 0;
        wb_read(REG_STATUS, st);
        while (!st[1]) begin
            polls++;
            if (polls > MAX_POLLS) begin
                abort_run("Command never reported done in STATUS");
            end
            wb_read(REG_STATUS, st);
        end
    endtask

    task automatic prepare_command(input resp_kind_e kind, input int mode);
        logic [6:0] crc_calc;
        logic [6:0] crc_rx;
        cur_kind   = kind;
        cur_cmd    = rand_bits(6);
        cur_arg    = rand_bits(32);
        card_mode  = mode;
        // R3 carries all ones in the index field
        card_cmd   = (kind == RESP_R3) ? 6'h3f : cur_cmd;
        card_val   = rand_bits(32);
        card_delay = 2 + int'(rand_bits(3) % 7);
        exp_frame  = {2'b01, cur_cmd, cur_arg, crc7_of({2'b01, cur_cmd, cur_arg}), 1'b1};
        crc_calc   = crc7_of({2'b00, card_cmd, card_val});
        crc_rx     = (mode == CARD_BAD_CRC) ? 7'h7f : crc_calc;
        exp_resp   = '{cmd: card_cmd, reg_val: card_val, crc_rx: crc_rx, crc_calc: crc_calc};
        if (mode == CARD_SILENT) begin
            exp_err = CMDERR_NO_RESPONSE;
        end else if (mode == CARD_BAD_STOP) begin
            exp_err = CMDERR_WRONG_RESP_STOPBIT;
        end else if (kind != RESP_R3 && crc_rx != crc_calc) begin
            exp_err = CMDERR_BAD_CRC;
        end else begin
            exp_err = CMDERR_NONE;
        end
    endtask

    task automatic send_command();
        wb_write(REG_ARG, cur_arg);
        wb_write(REG_CMD, {22'h0, cur_kind, 2'b00, cur_cmd});
        frames_sent++;
    endtask

    task automatic finish_command();
        logic [31:0] st;
        logic [31:0] w_cmd;
        logic [31:0] w_reg;
        logic [31:0] w_crc;
        cmd_resp_t   got;
        wait_done(st);
        check_word(32'(frame_count), 32'(frames_sent), "frame count");
        check_frame(last_frame, exp_frame);
        check_err(cmd_err_e'(st[6:4]), exp_err);
        check_word({30'h0, st[1:0]}, 32'h2, "STATUS done and busy");
        if (card_mode != CARD_SILENT) begin
            wb_read(REG_RESP_CMD, w_cmd);
            wb_read(REG_RESP_REG, w_reg);
            wb_read(REG_RESP_CRC, w_crc);
            got = '{cmd: w_cmd[5:0], reg_val: w_reg, crc_rx: w_crc[6:0], crc_calc: w_crc[14:8]};
            check_resp(got, exp_resp);
        end
    endtask

    // SD card model capturing host frames on rising edges and answering on falling edges
    initial begin : card_model
        logic [47:0] rx;
        logic [47:0] tx;
        logic [6:0]  crc;
        time         t_start;
        sd_cmd_in   = 1'b1;
        frame_count = 0;
        last_frame  = '0;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd_oe === 1'b1 && sd_cmd_out === 1'b0) begin
                t_start = $time;
                rx = '0;
                for (int i = 46; i >= 0; i--) begin
                    @(posedge sd_clk);
                    rx[i] = sd_cmd_out;
                end
                // Card clock period is 2 * (div + 1) system clocks
                check_word(32'($time - t_start), 32'(47 * 2 * (sd_div + 1) * CLK_PERIOD),
                           "SD clock time over 47 periods");
                last_frame = rx;
                frame_count++;
                if (card_mode != CARD_SILENT) begin
                    crc = crc7_of({2'b00, card_cmd, card_val});
                    if (card_mode == CARD_BAD_CRC) begin
                        crc = 7'h7f;
                    end
                    tx = {2'b00, card_cmd, card_val, crc, card_mode != CARD_BAD_STOP};
                    repeat (card_delay) @(negedge sd_clk);
                    for (int i = 47; i >= 0; i--) begin
                        @(negedge sd_clk);
                        @(negedge clk);
                        check_word(32'(sd_cmd_oe), 32'h0, "CMD output enable while card drives");
                        sd_cmd_in = tx[i];
                    end
                    @(negedge sd_clk);
                    @(negedge clk);
                    sd_cmd_in = 1'b1;
                end
            end
        end
    end

    initial begin : run_watchdog
        #(TIMEOUT_NS);
        abort_run("Watchdog timeout, the tests did not finish in time");
    end

    initial begin : main_seq
        logic [31:0] ctrl;
        logic [31:0] wdog;
        logic [31:0] arg;
        logic [31:0] rd;
        nrst        = 1'b0;
        wb_req      = '0;
        card_mode   = CARD_SILENT;
        card_cmd    = '0;
        card_val    = '0;
        card_delay  = 2;
        frames_sent = 0;
        sd_div      = '0;
        repeat (10) @(negedge clk);
        check_word(32'(wb_rsp.ack), 32'h0, "Wishbone ack in reset");
        check_word({29'h0, sd_clk, sd_cmd_oe, sd_cmd_out}, 32'h3, "SD clock, enable and CMD in reset");
        nrst = 1'b1;

        wb_read(REG_STATUS, rd);
        check_word(rd, 32'h0, "STATUS after reset");

        // Register read-back
        for (int r = 0; r < 4; r++) begin
            ctrl = rand_bits(32);
            wdog = rand_bits(32);
            arg  = rand_bits(32);
            wb_write(REG_CTRL, ctrl);
            wb_write(REG_WATCHDOG, wdog);
            wb_write(REG_ARG, arg);
            wb_read(REG_CTRL, rd);
            check_word(rd, ctrl & ((32'h1 << DIV_WIDTH) - 32'h1), "CTRL read-back");
            wb_read(REG_WATCHDOG, rd);
            check_word(rd, wdog & 32'hffff, "WATCHDOG read-back");
            wb_read(REG_ARG, rd);
            check_word(rd, arg, "ARG read-back");
        end

        // Watchdog must outlast the longest card delay
        sd_div = rand_bits(2);
        wb_write(REG_CTRL, sd_div);
        wb_write(REG_WATCHDOG, 32'd8 + rand_bits(3));

        for (int r = 0; r < N_ROUNDS; r++) begin
            wb_write(REG_STATUS, 32'h0);
            prepare_command(RESP_R1, CARD_GOOD);
            send_command();
            finish_command();
            wb_write(REG_STATUS, 32'h0);
            prepare_command(RESP_R6, CARD_GOOD);
            send_command();
            finish_command();
            wb_write(REG_STATUS, 32'h0);
            prepare_command(RESP_R3, CARD_BAD_CRC);
            send_command();
            finish_command();
            wb_write(REG_STATUS, 32'h0);
            prepare_command(RESP_R1, CARD_BAD_CRC);
            send_command();
            finish_command();
            wb_write(REG_STATUS, 32'h0);
            prepare_command(RESP_R1, CARD_SILENT);
            send_command();
            finish_command();
            wb_write(REG_STATUS, 32'h0);
            prepare_command(RESP_R6, CARD_BAD_STOP);
            send_command();
            finish_command();

            // The next command must wait while the stop bit error is pending
            prepare_command(RESP_R1, CARD_GOOD);
            send_command();
            repeat (HOLD_PERIODS) @(posedge sd_clk);
            check_word(32'(frame_count), 32'(frames_sent - 1), "frames while error pending");
            wb_read(REG_STATUS, rd);
            check_word({30'h0, rd[1:0]}, 32'h3, "STATUS while command held");
            check_err(cmd_err_e'(rd[6:4]), CMDERR_WRONG_RESP_STOPBIT);
            wb_write(REG_STATUS, 32'h0);
            finish_command();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
sd_cmd_pkg.sv
sd_clk_gen.sv
sd_crc7.sv
sd_cmd_transceiver.sv
sd_wb_regs.sv
sd_cmd_top.sv
tb_sd_cmd_top.sv

/* Bender.yml */
package:
  name: sd_cmd_ctrl

sources:
  - sd_cmd_pkg.sv
  - sd_clk_gen.sv
  - sd_crc7.sv
  - sd_cmd_transceiver.sv
  - sd_wb_regs.sv
  - sd_cmd_top.sv
  - target: test
    files:
      - tb_sd_cmd_top.sv
